//--- logic/credit_link_top.sv
// ############################
// Credit link top
// ############################

`timescale 1ns/1ps
`default_nettype none

module credit_link_top (
  input  logic                clk,
  input  logic                arst_n,
  // Source side.
  input  logic                src_valid,
  input  crlink_pkg::data_t   src_data,
  output logic                src_ready,
  // Sink side.
  output logic                snk_valid,
  output crlink_pkg::data_t   snk_data,
  input  logic                snk_ready,
  // Controls.
  input  crlink_pkg::credit_t credit_initial,
  input  crlink_pkg::credit_t credit_withhold,
  input  logic                credit_stall,
  input  logic                sender_reset,
  // Observation.
  output crlink_pkg::credit_t credit_count,
  output crlink_pkg::credit_t credit_available
);

  import crlink_pkg::*;

  // Link between sender and receiver.
  logic  push_valid;
  data_t push_data;
  logic  push_credit;
  logic  push_sender_in_reset;
  logic  push_receiver_in_reset;
  // Receiver to buffer.
  logic  buf_push;
  data_t buf_data;
  logic  pop_credit;

  credit_sender u_sender (
    .clk                  (clk),
    .arst_n               (arst_n),
    .sender_reset         (sender_reset),
    .src_valid            (src_valid),
    .src_data             (src_data),
    .src_ready            (src_ready),
    .push_credit          (push_credit),
    .push_valid           (push_valid),
    .push_data            (push_data),
    .push_sender_in_reset (push_sender_in_reset)
  );

  credit_receiver u_receiver (
    .clk                    (clk),
    .arst_n                 (arst_n),
    .push_sender_in_reset   (push_sender_in_reset),
    .push_receiver_in_reset (push_receiver_in_reset),
    .credit_stall           (credit_stall),
    .push_credit            (push_credit),
    .push_valid             (push_valid),
    .push_data              (push_data),
    .buf_push               (buf_push),
    .buf_data               (buf_data),
    .pop_credit             (pop_credit),
    .credit_initial         (credit_initial),
    .credit_withhold        (credit_withhold),
    .credit_count           (credit_count),
    .credit_available       (credit_available)
  );

  rx_buffer u_buffer (
    .clk        (clk),
    .arst_n     (arst_n),
    .buf_push   (buf_push),
    .buf_data   (buf_data),
    .snk_valid  (snk_valid),
    .snk_data   (snk_data),
    .snk_ready  (snk_ready),
    .pop_credit (pop_credit)
  );

  // The sender holds no credits while the receiver is in reset.
  // So nothing crosses the link then.
  no_push_in_link_reset_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    push_receiver_in_reset |-> !push_valid
  );

endmodule : credit_link_top

`default_nettype wire

//--- logic/credit_receiver.sv
// ############################
// Credit receiver
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "crlink_consts.svh"

module credit_receiver (
  input  logic                clk,
  input  logic                arst_n,
  // Link reset handshake.
  input  logic                push_sender_in_reset,
  output logic                push_receiver_in_reset,
  // Credit return control.
  input  logic                credit_stall,
  output logic                push_credit,
  // Incoming pushes.
  input  logic                push_valid,
  input  crlink_pkg::data_t   push_data,
  // Toward the receive buffer.
  output logic                buf_push,
  output crlink_pkg::data_t   buf_data,
  input  logic                pop_credit,
  // Pool setup and observation.
  input  crlink_pkg::credit_t credit_initial,
  input  crlink_pkg::credit_t credit_withhold,
  output crlink_pkg::credit_t credit_count,
  output crlink_pkg::credit_t credit_available
);

  import crlink_pkg::*;

  link_state_e state;
  link_state_e state_nxt;
  // A credit leaves the pool for the sender this cycle.
  logic        return_now;

  // Link state machine.
  // Stays in LINK_RESET while the sender is held in reset.
  always_comb begin
    state_nxt = push_sender_in_reset ? LINK_RESET : LINK_ACTIVE;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= LINK_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  assign push_receiver_in_reset = (state == LINK_RESET);

  // Withheld credits are kept out of circulation.
  always_comb begin
    if (credit_count > credit_withhold) begin
      credit_available = credit_count - credit_withhold;
    end else begin
      credit_available = '0;
    end
  end

  // No return while the sender is going into reset.
  // Its counter would miss the credit.
  assign return_now = (state == LINK_ACTIVE) && !push_sender_in_reset &&
                      (credit_available != '0) && !credit_stall;

  // Credit pool.
  // Reloaded in LINK_RESET, then moved by pops and returns.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_count <= '0;
    end else if (state == LINK_RESET) begin
      credit_count <= credit_initial;
    end else begin
      credit_count <= credit_count + credit_t'(pop_credit) - credit_t'(return_now);
    end
  end

  // Registered credit return, one per cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_credit <= 1'b0;
    end else begin
      push_credit <= return_now;
    end
  end

  // Pushes go straight into the buffer.
  assign buf_push = push_valid;
  assign buf_data = push_data;

  // Withhold must fit within a full pool.
  withhold_legal_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    credit_withhold <= credit_t'(`CRL_MAX_CREDIT)
  );

  // A pop credit was out of the pool, so the pool sits below its initial value.
  pop_within_initial_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == LINK_ACTIVE) && pop_credit |-> credit_count < credit_initial
  );

endmodule : credit_receiver

`default_nettype wire

//--- logic/credit_sender.sv
// ############################
// Credit sender
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "crlink_consts.svh"

module credit_sender (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              sender_reset,
  // Source side, ready/valid.
  input  logic              src_valid,
  input  crlink_pkg::data_t src_data,
  output logic              src_ready,
  // Link side, credit/valid.
  input  logic              push_credit,
  output logic              push_valid,
  output crlink_pkg::data_t push_data,
  output logic              push_sender_in_reset
);

  import crlink_pkg::*;

  // Credits currently held by the sender.
  credit_t credit_cnt;
  // Source handshake in this cycle.
  logic    accept;

  // The receiver watches this to reload its pool.
  assign push_sender_in_reset = sender_reset;

  // Ready while a credit is held.
  // A credit arriving this cycle may be spent right away.
  assign src_ready = (credit_cnt != '0) || push_credit;
  assign accept    = src_valid && src_ready;

  // Credit counter.
  // The credit is spent at accept, one cycle before the push shows up.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= '0;
    end else if (sender_reset) begin
      // All held credits go back to the receiver pool.
      credit_cnt <= '0;
    end else begin
      credit_cnt <= credit_cnt + credit_t'(push_credit) - credit_t'(accept);
    end
  end

  // Push valid register.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_valid <= 1'b0;
    end else if (sender_reset) begin
      push_valid <= 1'b0;
    end else begin
      push_valid <= accept;
    end
  end

  // Push data register.
  // Loaded only on accept.
  always_ff @(posedge clk) begin
    if (accept) begin
      push_data <= src_data;
    end
  end

  // The sender never holds more than a full pool.
  credit_cnt_bound_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    credit_cnt <= credit_t'(`CRL_MAX_CREDIT)
  );

endmodule : credit_sender

`default_nettype wire

//--- logic/crlink_consts.svh
// ############################
// Credit link sizes
// ############################

`ifndef CRLINK_CONSTS_SVH
`define CRLINK_CONSTS_SVH

// Width of one data word in bits.
`define CRL_DATA_WIDTH 8

// Largest credit pool.
// Also the depth of the receive buffer.
`define CRL_MAX_CREDIT 4

// Counter width for values 0 through CRL_MAX_CREDIT.
`define CRL_CNT_WIDTH 3

`endif

//--- logic/crlink_pkg.sv
// ############################
// Credit link types
// ############################

`default_nettype none

`include "crlink_consts.svh"

package crlink_pkg;

  // One word carried across the link.
  typedef logic [`CRL_DATA_WIDTH-1:0] data_t;

  // Credit count, wide enough for a full pool.
  typedef logic [`CRL_CNT_WIDTH-1:0] credit_t;

  // Receiver link state.
  // No credits are returned in LINK_RESET.
  typedef enum logic {
    LINK_RESET  = 1'b0,
    LINK_ACTIVE = 1'b1
  } link_state_e;

endpackage : crlink_pkg

`default_nettype wire

//--- logic/rx_buffer.sv
// ############################
// Receive buffer
// ############################

`timescale 1ns/1ps
`default_nettype none

`include "crlink_consts.svh"

module rx_buffer (
  input  logic              clk,
  input  logic              arst_n,
  // Write side from the receiver.
  input  logic              buf_push,
  input  crlink_pkg::data_t buf_data,
  // Sink side, ready/valid.
  output logic              snk_valid,
  output crlink_pkg::data_t snk_data,
  input  logic              snk_ready,
  // One credit back per dequeue.
  output logic              pop_credit
);

  import crlink_pkg::*;

  localparam int ptr_width = $clog2(`CRL_MAX_CREDIT);

  // Storage has no reset.
  data_t                mem [`CRL_MAX_CREDIT];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  // Number of words held.
  credit_t              fill;
  logic                 do_pop;

  assign snk_valid = (fill != '0);
  assign snk_data  = mem[rd_ptr];
  assign do_pop    = snk_valid && snk_ready;

  always_ff @(posedge clk) begin
    if (buf_push) begin
      mem[wr_ptr] <= buf_data;
    end
  end

  // Pointers, fill count and pop credit.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      pop_credit <= 1'b0;
    end else begin
      if (buf_push) begin
        wr_ptr <= (wr_ptr == ptr_width'(`CRL_MAX_CREDIT - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(`CRL_MAX_CREDIT - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill       <= fill + credit_t'(buf_push) - credit_t'(do_pop);
      // Credit goes back the cycle after the sink takes the word.
      pop_credit <= do_pop;
    end
  end

  // A push into a full buffer means the sender overspent its credits.
  no_push_when_full_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    buf_push |-> fill != credit_t'(`CRL_MAX_CREDIT)
  );

endmodule : rx_buffer

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the credit link testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sim.f --top-module tb_credit_link -o sim_credit_link

output=$(./obj_dir/sim_credit_link)
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

//--- sim.f
+incdir+logic
logic/crlink_pkg.sv
logic/credit_sender.sv
logic/credit_receiver.sv
logic/rx_buffer.sv
logic/credit_link_top.sv
tb/tb_credit_link.sv

//--- tb/tb_credit_link.sv
// ############################
// Credit link testbench
// ############################

`timescale 1ns/1ps
`default_nettype none

module tb_credit_link;

  import crlink_pkg::*;

  localparam int num_rows       = 8;
  localparam int timeout_cycles = 200 * num_rows;
  localparam int settle_cycles  = 8;

  // One test row.
  // expect_stalled is the word count accepted while the sink is held.
  typedef struct packed {
    credit_t init;
    credit_t whold;
    logic    stall;
    int      words;
    logic    sink_stalled;
    int      expect_stalled;
  } row_t;

  logic    clk = 1'b0;
  logic    arst_n;
  logic    src_valid;
  data_t   src_data;
  logic    src_ready;
  logic    snk_valid;
  data_t   snk_data;
  logic    snk_ready;
  credit_t credit_initial;
  credit_t credit_withhold;
  logic    credit_stall;
  logic    sender_reset;
  credit_t credit_count;
  credit_t credit_available;

  row_t  rows [num_rows];
  // Words accepted by the DUT and not yet seen at the sink.
  data_t ref_q [$];
  data_t expected_word;
  int    words_sent   = 0;
  int    words_rcvd   = 0;
  int    words_target = 0;
  int    errors       = 0;
  int    rows_failed  = 0;
  int    cycle_cnt    = 0;
  logic  src_run      = 1'b0;
  logic  sink_hold    = 1'b1;

  credit_link_top dut (
    .clk              (clk),
    .arst_n           (arst_n),
    .src_valid        (src_valid),
    .src_data         (src_data),
    .src_ready        (src_ready),
    .snk_valid        (snk_valid),
    .snk_data         (snk_data),
    .snk_ready        (snk_ready),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .credit_stall     (credit_stall),
    .sender_reset     (sender_reset),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  // 100 ns period.
  always #50 clk = ~clk;

  // Pool minus withhold, never below zero.
  function automatic credit_t floor_sub(input credit_t a, input credit_t b);
    return (a > b) ? credit_t'(a - b) : '0;
  endfunction

  function automatic credit_t min_credit(input credit_t a, input credit_t b);
    return (a < b) ? a : b;
  endfunction

  // Columns: initial, withhold, stall, words, sink held, accepted while held.
  task automatic fill_table();
    rows[0] = '{3'd4, 3'd0, 1'b0, 16, 1'b0, 0};
    rows[1] = '{3'd4, 3'd0, 1'b0, 10, 1'b1, 4};
    rows[2] = '{3'd2, 3'd0, 1'b0, 8,  1'b1, 2};
    rows[3] = '{3'd4, 3'd1, 1'b0, 10, 1'b1, 3};
    rows[4] = '{3'd2, 3'd3, 1'b0, 6,  1'b1, 0};
    rows[5] = '{3'd3, 3'd0, 1'b1, 8,  1'b1, 0};
    rows[6] = '{3'd4, 3'd2, 1'b0, 12, 1'b0, 0};
    rows[7] = '{3'd1, 3'd0, 1'b0, 6,  1'b1, 1};
  endtask

  // Source.
  // Holds a word until accepted, then offers the next one.
  always @(posedge clk) begin
    if (src_valid && src_ready) begin
      ref_q.push_back(src_data);
      words_sent++;
    end
    if (!src_valid || src_ready) begin
      if (src_run && words_sent < words_target) begin
        src_valid <= 1'b1;
        src_data  <= data_t'($urandom);
      end else begin
        src_valid <= 1'b0;
      end
    end
  end

  // Sink with random back-pressure, unless held.
  always @(posedge clk) begin
    if (snk_valid && snk_ready) begin
      words_rcvd++;
      assert (ref_q.size() != 0) else begin
        $display("Sink delivered a word at %0t with none outstanding.", $time);
        errors++;
      end
      if (ref_q.size() != 0) begin
        expected_word = ref_q.pop_front();
        assert (snk_data == expected_word) else begin
          $display("[ERROR] %0t: sink data %h, expected %h", $time, snk_data, expected_word);
          errors++;
        end
      end
    end
    snk_ready <= sink_hold ? 1'b0 : ($urandom_range(3) != 0);
  end

  // Run limit.
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Run did not finish within %0d cycles; the link stopped making progress.",
               timeout_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Waits until word counts and credit outputs stop changing.
  task automatic wait_settled(input int quiet);
    int      still;
    int      snap_sent;
    int      snap_rcvd;
    credit_t snap_cnt;
    credit_t snap_av;
    still     = 0;
    snap_sent = words_sent;
    snap_rcvd = words_rcvd;
    snap_cnt  = credit_count;
    snap_av   = credit_available;
    while (still < quiet) begin
      @(negedge clk);
      if (words_sent == snap_sent && words_rcvd == snap_rcvd &&
          credit_count == snap_cnt && credit_available == snap_av) begin
        still++;
      end else begin
        still     = 0;
        snap_sent = words_sent;
        snap_rcvd = words_rcvd;
        snap_cnt  = credit_count;
        snap_av   = credit_available;
      end
    end
  endtask

  task automatic run_row(input int idx);
    row_t    r;
    int      err_start;
    int      held_back;
    credit_t final_whold;
    r           = rows[idx];
    err_start   = errors;
    held_back   = 0;
    final_whold = r.whold;
    // New setup, then a sender reset while the link is idle.
    @(posedge clk);
    credit_initial  <= r.init;
    credit_withhold <= r.whold;
    credit_stall    <= r.stall;
    sender_reset    <= 1'b1;
    @(posedge clk);
    sender_reset <= 1'b0;
    // Receiver spends one cycle in LINK_RESET and reloads the pool.
    @(posedge clk);
    @(negedge clk);
    assert (credit_count == r.init) else begin
      $display("[ERROR] %0t: pool %0d after reset, expected %0d", $time, credit_count, r.init);
      errors++;
    end
    sink_hold    = r.sink_stalled;
    words_sent   = 0;
    words_rcvd   = 0;
    words_target = r.words;
    src_run      = 1'b1;
    if (r.sink_stalled) begin
      wait_settled(settle_cycles);
      held_back = words_sent;
      assert (words_sent == r.expect_stalled) else begin
        $display("[ERROR] %0t: %0d words accepted with sink held, expected %0d",
                 $time, words_sent, r.expect_stalled);
        errors++;
      end
      // With a stall nothing is returned; otherwise returns stop at the withhold.
      assert (credit_count == (r.stall ? r.init : min_credit(r.init, r.whold))) else begin
        $display("[ERROR] %0t: pool %0d with sink held", $time, credit_count);
        errors++;
      end
      assert (credit_available == (r.stall ? floor_sub(r.init, r.whold) : '0)) else begin
        $display("[ERROR] %0t: available %0d with sink held", $time, credit_available);
        errors++;
      end
      // Release stall and withhold, then the sink.
      @(posedge clk);
      credit_stall    <= 1'b0;
      credit_withhold <= '0;
      final_whold = '0;
      @(negedge clk);
      sink_hold = 1'b0;
    end
    while (words_rcvd < r.words) begin
      @(negedge clk);
    end
    wait_settled(settle_cycles);
    src_run = 1'b0;
    assert (ref_q.size() == 0) else begin
      $display("%0d accepted words were never delivered to the sink.", ref_q.size());
      errors++;
    end
    // Drained link, the receiver keeps only the withheld part.
    assert (credit_count == min_credit(r.init, final_whold)) else begin
      $display("[ERROR] %0t: pool %0d after drain, expected %0d",
               $time, credit_count, min_credit(r.init, final_whold));
      errors++;
    end
    assert (credit_available == '0) else begin
      $display("[ERROR] %0t: available %0d after drain", $time, credit_available);
      errors++;
    end
    if (errors != err_start) begin
      rows_failed++;
    end
    $display("row %0d: initial=%0d withhold=%0d stall=%0d words=%0d held=%0d delivered=%0d %s",
             idx, r.init, r.whold, r.stall, r.words, held_back, words_rcvd,
             (errors == err_start) ? "ok" : "mismatch");
  endtask

  initial begin
    void'($urandom(32'hcc89f0ce));
    arst_n          = 1'b0;
    src_valid       = 1'b0;
    src_data        = '0;
    snk_ready       = 1'b0;
    credit_initial  = '0;
    credit_withhold = '0;
    credit_stall    = 1'b0;
    sender_reset    = 1'b0;
    fill_table();
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < num_rows; i++) begin
      run_row(i);
    end
    $display("rows: %0d, rows failed: %0d, errors: %0d", num_rows, rows_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_credit_link

`default_nettype wire
